//--- Makefile
# Verilator build and run for the pooling pipeline testbench

VERILATOR ?= verilator
TOP       ?= pool_tb
OBJ_DIR   ?= obj_dir
FLIST     ?= flist.f
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= NO ERRORS

SRCS := pool_consts.svh \
	pool_pkg.sv \
	wb_cfg_port.sv \
	pool_stage.sv \
	relu_stage.sv \
	pool_top.sv \
	pool_assertions.sv \
	pool_clk_gen.sv \
	pool_tb.sv

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# status follows the search for the pass line in the simulator output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
+incdir+.
pool_pkg.sv
wb_cfg_port.sv
pool_stage.sv
relu_stage.sv
pool_top.sv
pool_assertions.sv
pool_clk_gen.sv
pool_tb.sv

//--- pool_assertions.sv
`timescale 1ns/100ps

module pool_assertions (
	input logic                 clk,
	input logic                 rst,
	input logic                 cyc,
	input logic                 stb,
	input logic                 ack,
	input logic                 ofm_valid,
	input pool_pkg::word_t      ofm_data,
	input pool_pkg::pool_mode_t pool_mode
);

	// number of failed properties
	int fail_count;

	initial fail_count = 0;

	// ack only inside an active bus cycle
	ack_in_cycle: assert property (@(posedge clk) disable iff (rst) ack |-> (cyc && stb))
		else begin
			$error("ack seen without cyc and stb");
			fail_count++;
		end

	ack_single: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
		else begin
			$error("ack high on two consecutive cycles");
			fail_count++;
		end

	out_quiet_after_rst: assert property (@(posedge clk) rst |=> !ofm_valid)
		else begin
			$error("ofm_valid high in the cycle after reset");
			fail_count++;
		end

	// pooled words only fill the two low lanes
	pooled_upper_zero: assert property (@(posedge clk) disable iff (rst)
		(ofm_valid && pool_mode == pool_pkg::POOL_2X2) |->
		(ofm_data[2] == '0 && ofm_data[3] == '0))
		else begin
			$error("upper lanes of a pooled word are not zero");
			fail_count++;
		end

endmodule

bind pool_top pool_assertions u_assertions (
	.clk       (clk),
	.rst       (rst),
	.cyc       (cyc),
	.stb       (stb),
	.ack       (ack),
	.ofm_valid (ofm_valid),
	.ofm_data  (ofm_data),
	.pool_mode (pool_mode)
);

//--- pool_clk_gen.sv
`timescale 1ns/100ps

module pool_clk_gen (
	output logic clk,
	output logic rst
);

	localparam real HALF_PERIOD = 2.0;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// reset covers three rising edges and drops on a falling edge
	initial begin
		rst = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

//--- pool_consts.svh
`ifndef POOL_CONSTS_SVH
`define POOL_CONSTS_SVH

// pixels carried in one bus word
`define POOL_LANES 4

// signed Q7.9 pixel
`define POOL_DATA_WIDTH 16
`define POOL_WORD_WIDTH (`POOL_LANES * `POOL_DATA_WIDTH)
`define POOL_Q 9

// leaky slope of 5/512 is close to 0.01
`define POOL_RELU_PARAM 5

// row buffer holds one even row of pair maxima
`define POOL_MAX_ROW_WORDS 8
`define POOL_ROW_BITS 4

`endif

//--- pool_pkg.sv
`include "pool_consts.svh"

package pool_pkg;

	// cfg bit 0
	typedef enum logic [0:0] {
		POOL_OFF = 1'b0,
		POOL_2X2 = 1'b1
	} pool_mode_t;

	// cfg bit 1
	typedef enum logic [0:0] {
		ACT_LEAKY  = 1'b0,
		ACT_LINEAR = 1'b1
	} act_mode_t;

	typedef enum logic [0:0] {
		REG_CFG  = 1'b0,
		REG_DATA = 1'b1
	} reg_addr_t;

	typedef logic signed [`POOL_DATA_WIDTH-1:0] pixel_t;
	typedef pixel_t [`POOL_LANES-1:0] word_t;

endpackage

//--- pool_stage.sv
`timescale 1ns/100ps
`include "pool_consts.svh"

module pool_stage (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      in_valid,
	input  logic                      cfg_load,
	input  pool_pkg::word_t           in_word,
	input  pool_pkg::pool_mode_t      pool_mode,
	input  logic [`POOL_ROW_BITS-1:0] row_words,
	output logic                      mid_valid,
	output pool_pkg::word_t           mid_word
);

	localparam int HALF     = `POOL_LANES / 2;
	localparam int COL_BITS = $clog2(`POOL_MAX_ROW_WORDS);

	logic [`POOL_ROW_BITS-1:0]   col;
	logic                        odd_row;
	logic                        last_col;
	logic                        pool_en;
	pool_pkg::pixel_t [HALF-1:0] pair_max;
	pool_pkg::pixel_t [HALF-1:0] stored;
	pool_pkg::pixel_t [HALF-1:0] row_buf [`POOL_MAX_ROW_WORDS];
	pool_pkg::word_t             pooled;

	function automatic pool_pkg::pixel_t smax(
		input pool_pkg::pixel_t a,
		input pool_pkg::pixel_t b
	);
		return ($signed(a) > $signed(b)) ? a : b;
	endfunction

	assign pool_en  = (pool_mode == pool_pkg::POOL_2X2);
	assign last_col = (col == row_words - 1'b1);
	assign stored   = row_buf[col[COL_BITS-1:0]];

	// horizontal max over lane pairs, then vertical max against the stored row
	always_comb begin
		pooled = '0;
		for (int i = 0; i < HALF; i++) begin
			pair_max[i] = smax(in_word[2*i], in_word[2*i+1]);
			pooled[i]   = smax(pair_max[i], stored[i]);
		end
	end

	// column index and row parity only advance on pooled words
	always_ff @(posedge clk) begin
		if (rst || cfg_load) begin
			col     <= '0;
			odd_row <= 1'b0;
		end else if (in_valid && pool_en) begin
			if (last_col) begin
				col     <= '0;
				odd_row <= !odd_row;
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	// even row leaves its pair maxima for the odd row below it
	always_ff @(posedge clk) begin
		if (in_valid && pool_en && !odd_row) begin
			row_buf[col[COL_BITS-1:0]] <= pair_max;
		end
	end

	// even rows in pool mode give no output
	always_ff @(posedge clk) begin
		if (rst) begin
			mid_valid <= 1'b0;
		end else begin
			mid_valid <= in_valid && (!pool_en || odd_row);
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			mid_word <= pool_en ? pooled : in_word;
		end
	end

endmodule

//--- pool_tb.sv
`timescale 1ns/100ps
`include "pool_consts.svh"

module pool_tb;

	localparam int TIMEOUT   = 200;
	localparam int OFF_WORDS = 40;

	logic                        clk;
	logic                        rst;
	logic                        cyc;
	logic                        stb;
	logic                        we;
	logic                        ack;
	logic                        ofm_valid;
	pool_pkg::reg_addr_t         adr;
	logic [`POOL_WORD_WIDTH-1:0] dat_w;
	logic [`POOL_WORD_WIDTH-1:0] dat_r;
	pool_pkg::word_t             ofm_data;

	pool_pkg::word_t      expect_q[$];
	pool_pkg::word_t      exp_w;
	int                   value_errors;
	int                   extra_words;
	int                   missing_words;
	int                   assert_fails;
	// reference model state
	pool_pkg::pool_mode_t m_pool;
	pool_pkg::act_mode_t  m_act;
	int                   m_row_words;
	int                   m_col;
	bit                   m_odd;
	pool_pkg::pixel_t     m_buf [`POOL_MAX_ROW_WORDS][2];

	pool_clk_gen u_clk_gen (
		.clk (clk),
		.rst (rst)
	);

	pool_top DUT (
		.clk       (clk),
		.rst       (rst),
		.cyc       (cyc),
		.stb       (stb),
		.we        (we),
		.adr       (adr),
		.dat_w     (dat_w),
		.dat_r     (dat_r),
		.ack       (ack),
		.ofm_valid (ofm_valid),
		.ofm_data  (ofm_data)
	);

	function automatic pool_pkg::pixel_t max_of(input pool_pkg::pixel_t a,
			input pool_pkg::pixel_t b);
		if (a < b) return b;
		return a;
	endfunction

	// negative pixels are scaled by slope / 2^Q and floored
	function automatic pool_pkg::pixel_t activate(input pool_pkg::pixel_t p);
		real scaled;
		scaled = $floor(real'(p) * `POOL_RELU_PARAM / (2.0 ** `POOL_Q));
		if (p >= 0 || m_act == pool_pkg::ACT_LINEAR) return p;
		return pool_pkg::pixel_t'(int'(scaled));
	endfunction

	function automatic logic [`POOL_WORD_WIDTH-1:0] cfg_value(input pool_pkg::pool_mode_t pm,
			input pool_pkg::act_mode_t am, input int rw);
		return {56'd0, 4'(rw), 2'b00, am, pm};
	endfunction

	function automatic pool_pkg::word_t rand_word();
		return {$urandom, $urandom};
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$finish;
	endtask

	task automatic model_data(input pool_pkg::word_t w);
		pool_pkg::word_t  res;
		pool_pkg::pixel_t pm0;
		pool_pkg::pixel_t pm1;
		bit               emit;
		res  = w;
		emit = (m_pool == pool_pkg::POOL_OFF) || m_odd;
		if (m_pool == pool_pkg::POOL_2X2) begin
			pm0 = max_of(w[0], w[1]);
			pm1 = max_of(w[2], w[3]);
			res = '0;
			if (!m_odd) begin
				m_buf[m_col][0] = pm0;
				m_buf[m_col][1] = pm1;
			end else begin
				res[0] = max_of(pm0, m_buf[m_col][0]);
				res[1] = max_of(pm1, m_buf[m_col][1]);
			end
			if (m_col == m_row_words - 1) begin
				m_col = 0;
				m_odd = !m_odd;
			end else begin
				m_col++;
			end
		end
		for (int i = 0; i < `POOL_LANES; i++) begin
			res[i] = activate(res[i]);
		end
		if (emit) expect_q.push_back(res);
	endtask

	// called on a falling edge and returns on one after the ack cycle
	task automatic bus_cycle(input logic is_write, input pool_pkg::reg_addr_t a,
			input logic [`POOL_WORD_WIDTH-1:0] d, output logic [`POOL_WORD_WIDTH-1:0] r);
		int n;
		cyc   = 1'b1;
		stb   = 1'b1;
		we    = is_write;
		adr   = a;
		dat_w = d;
		n     = 0;
		@(negedge clk);
		while (ack !== 1'b1) begin
			if (n == TIMEOUT) abort_run("no ack from the bus slave within the timeout");
			n++;
			@(negedge clk);
		end
		r = dat_r;
		@(negedge clk);
		cyc = 1'b0;
		stb = 1'b0;
		we  = 1'b0;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (expect_q.size() != 0 && n < TIMEOUT) begin
			n++;
			@(negedge clk);
		end
		if (expect_q.size() != 0) begin
			$display("%0d expected output words never arrived", expect_q.size());
			missing_words += expect_q.size();
			expect_q.delete();
		end
		repeat (4) @(negedge clk);
	endtask

	task automatic write_cfg(input pool_pkg::pool_mode_t pm, input pool_pkg::act_mode_t am,
			input int rw);
		logic [`POOL_WORD_WIDTH-1:0] unused;
		wait_idle();
		bus_cycle(1'b1, pool_pkg::REG_CFG, cfg_value(pm, am, rw), unused);
		m_pool      = pm;
		m_act       = am;
		m_row_words = rw;
		m_col       = 0;
		m_odd       = 1'b0;
	endtask

	task automatic write_data(input pool_pkg::word_t w);
		logic [`POOL_WORD_WIDTH-1:0] unused;
		model_data(w);
		bus_cycle(1'b1, pool_pkg::REG_DATA, w, unused);
	endtask

	task automatic read_check(input pool_pkg::reg_addr_t a,
			input logic [`POOL_WORD_WIDTH-1:0] exp);
		logic [`POOL_WORD_WIDTH-1:0] got;
		bus_cycle(1'b0, a, '0, got);
		if (got !== exp) begin
			$display("error dat_r expected %h got %h", exp, got);
			value_errors++;
		end
	endtask

	// every output word is matched against the model queue
	always @(negedge clk) begin
		if (!rst && ofm_valid) begin
			if (expect_q.size() == 0) begin
				$display("output word %h arrived when none was expected", ofm_data);
				extra_words++;
			end else begin
				exp_w = expect_q.pop_front();
				if (ofm_data !== exp_w) begin
					$display("error ofm_data expected %h got %h", exp_w, ofm_data);
					value_errors++;
				end
			end
		end
	end

	initial begin : main
		int                   n;
		int                   rw;
		pool_pkg::pool_mode_t pm;
		pool_pkg::act_mode_t  am;
		cyc           = 1'b0;
		stb           = 1'b0;
		we            = 1'b0;
		adr           = pool_pkg::REG_CFG;
		dat_w         = '0;
		value_errors  = 0;
		extra_words   = 0;
		missing_words = 0;
		assert_fails  = 0;
		m_pool        = pool_pkg::POOL_OFF;
		m_act         = pool_pkg::ACT_LEAKY;
		m_row_words   = 1;
		m_col         = 0;
		m_odd         = 1'b0;
		void'($urandom(32'h49a4));
		n = 0;
		while (rst !== 1'b0) begin
			if (n == TIMEOUT) abort_run("reset never released");
			n++;
			@(negedge clk);
		end
		repeat (6) begin
			@(negedge clk);
			if (ofm_valid !== 1'b0) begin
				$display("error ofm_valid expected 0 got %h", ofm_valid);
				value_errors++;
			end
		end
		read_check(pool_pkg::REG_CFG, cfg_value(pool_pkg::POOL_OFF, pool_pkg::ACT_LEAKY, 1));
		repeat (4) begin
			pm = pool_pkg::pool_mode_t'($urandom % 2);
			am = pool_pkg::act_mode_t'($urandom % 2);
			rw = 1 + int'($urandom % 8);
			write_cfg(pm, am, rw);
			read_check(pool_pkg::REG_CFG, cfg_value(pm, am, rw));
			read_check(pool_pkg::REG_DATA, '0);
		end
		write_cfg(pool_pkg::POOL_OFF, pool_pkg::ACT_LEAKY, 1);
		repeat (OFF_WORDS) write_data(rand_word());
		write_cfg(pool_pkg::POOL_OFF, pool_pkg::ACT_LINEAR, 1);
		repeat (20) write_data(rand_word());
		// three row pairs per configuration
		for (int k = 0; k < 4; k++) begin
			rw = 1 + int'($urandom % 8);
			write_cfg(pool_pkg::POOL_2X2, pool_pkg::act_mode_t'(k % 2), rw);
			repeat (6 * rw) write_data(rand_word());
		end
		// half an even row, then a config write restarts the row position
		rw = 2 + int'($urandom % 7);
		write_cfg(pool_pkg::POOL_2X2, pool_pkg::ACT_LEAKY, rw);
		repeat (rw / 2) write_data(rand_word());
		write_cfg(pool_pkg::POOL_2X2, pool_pkg::ACT_LEAKY, rw);
		repeat (4 * rw) write_data(rand_word());
		wait_idle();
		assert_fails = DUT.u_assertions.fail_count;
		$display("value errors %0d, extra words %0d, missing words %0d, assertion fails %0d",
			value_errors, extra_words, missing_words, assert_fails);
		if (value_errors + extra_words + missing_words + assert_fails == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

//--- pool_top.sv
`timescale 1ns/100ps
`include "pool_consts.svh"

module pool_top (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        cyc,
	input  logic                        stb,
	input  logic                        we,
	input  pool_pkg::reg_addr_t         adr,
	input  logic [`POOL_WORD_WIDTH-1:0] dat_w,
	output logic [`POOL_WORD_WIDTH-1:0] dat_r,
	output logic                        ack,
	output logic                        ofm_valid,
	output pool_pkg::word_t             ofm_data
);

	logic                      in_valid;
	pool_pkg::word_t           in_word;
	pool_pkg::pool_mode_t      pool_mode;
	pool_pkg::act_mode_t       act_mode;
	logic [`POOL_ROW_BITS-1:0] row_words;
	logic                      cfg_load;
	logic                      mid_valid;
	pool_pkg::word_t           mid_word;

	// bus slave, config register and word issue
	wb_cfg_port u_port (
		.clk       (clk),
		.rst       (rst),
		.cyc       (cyc),
		.stb       (stb),
		.we        (we),
		.adr       (adr),
		.dat_w     (dat_w),
		.dat_r     (dat_r),
		.ack       (ack),
		.in_valid  (in_valid),
		.in_word   (in_word),
		.pool_mode (pool_mode),
		.act_mode  (act_mode),
		.row_words (row_words),
		.cfg_load  (cfg_load)
	);

	pool_stage u_pool (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.cfg_load  (cfg_load),
		.in_word   (in_word),
		.pool_mode (pool_mode),
		.row_words (row_words),
		.mid_valid (mid_valid),
		.mid_word  (mid_word)
	);

	// every valid word must be taken as there is no back-pressure
	relu_stage u_relu (
		.clk       (clk),
		.rst       (rst),
		.mid_valid (mid_valid),
		.mid_word  (mid_word),
		.act_mode  (act_mode),
		.ofm_valid (ofm_valid),
		.ofm_data  (ofm_data)
	);

endmodule

//--- relu_stage.sv
`timescale 1ns/100ps
`include "pool_consts.svh"

module relu_stage (
	input  logic                clk,
	input  logic                rst,
	input  logic                mid_valid,
	input  pool_pkg::word_t     mid_word,
	input  pool_pkg::act_mode_t act_mode,
	output logic                ofm_valid,
	output pool_pkg::word_t     ofm_data
);

	logic signed [2*`POOL_DATA_WIDTH-1:0] prod [`POOL_LANES];
	pool_pkg::word_t                      act_word;

	always_comb begin
		for (int i = 0; i < `POOL_LANES; i++) begin
			// full-width product, then drop the Q fraction bits
			prod[i] = $signed(mid_word[i]) * `POOL_RELU_PARAM;
			if (act_mode == pool_pkg::ACT_LEAKY && mid_word[i][`POOL_DATA_WIDTH-1]) begin
				// arithmetic shift floors toward minus infinity
				act_word[i] = pool_pkg::pixel_t'(prod[i] >>> `POOL_Q);
			end else begin
				act_word[i] = mid_word[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ofm_valid <= 1'b0;
		end else begin
			ofm_valid <= mid_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (mid_valid) begin
			ofm_data <= act_word;
		end
	end

endmodule

//--- wb_cfg_port.sv
`timescale 1ns/100ps
`include "pool_consts.svh"

module wb_cfg_port (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        cyc,
	input  logic                        stb,
	input  logic                        we,
	input  pool_pkg::reg_addr_t         adr,
	input  logic [`POOL_WORD_WIDTH-1:0] dat_w,
	output logic [`POOL_WORD_WIDTH-1:0] dat_r,
	output logic                        ack,
	output logic                        in_valid,
	output pool_pkg::word_t             in_word,
	output pool_pkg::pool_mode_t        pool_mode,
	output pool_pkg::act_mode_t         act_mode,
	output logic [`POOL_ROW_BITS-1:0]   row_words,
	output logic                        cfg_load
);

	logic       req;
	logic       wr_cfg;
	logic       wr_data;
	logic [7:0] cfg_byte;

	// a new cycle is only taken when ack was low, so acks are never back to back
	assign req     = cyc && stb && !ack;
	assign wr_cfg  = req && we && (adr == pool_pkg::REG_CFG);
	assign wr_data = req && we && (adr == pool_pkg::REG_DATA);

	// row length sits in the upper nibble and bits 3:2 stay unused
	assign cfg_byte = {row_words, 2'b00, act_mode, pool_mode};

	// master holds adr until ack, so a combinational read is stable on the ack cycle
	assign dat_r = (adr == pool_pkg::REG_CFG) ?
		{{(`POOL_WORD_WIDTH - 8){1'b0}}, cfg_byte} : '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			ack       <= 1'b0;
			in_valid  <= 1'b0;
			cfg_load  <= 1'b0;
			pool_mode <= pool_pkg::POOL_OFF;
			act_mode  <= pool_pkg::ACT_LEAKY;
			row_words <= `POOL_ROW_BITS'(1);
		end else begin
			ack      <= req;
			in_valid <= wr_data;
			cfg_load <= wr_cfg;
			if (wr_cfg) begin
				pool_mode <= pool_pkg::pool_mode_t'(dat_w[0]);
				act_mode  <= pool_pkg::act_mode_t'(dat_w[1]);
				row_words <= dat_w[7:4];
			end
		end
	end

	// pixel word is captured on the same edge as in_valid
	always_ff @(posedge clk) begin
		if (wr_data) begin
			in_word <= dat_w;
		end
	end

endmodule
